// File: mac_rx_pkg.sv
package mac_rx_pkg;

    //************************************************************
    // xgmii control characters and sizing
    //************************************************************
    localparam logic [7:0] XGMII_IDLE  = 8'h07;        // idle char
    localparam logic [7:0] XGMII_START = 8'hfb;        // start char, lane 0 only
    localparam logic [7:0] XGMII_TERM  = 8'hfd;        // terminate char, any lane

    localparam int BEAT_BYTES      = 8;                // bytes per 64b beat
    localparam int MIN_FRAME_BYTES = 64;               // undersize below this
    localparam int RX_FIFO_DEPTH   = 64;               // data fifo, in beats
    localparam int LEN_FIFO_DEPTH  = 16;               // length fifo, in frames
    localparam int MAX_FRAME_BEATS = 24;               // room kept free per frame

    //************************************************************
    // bus types
    //************************************************************
    typedef struct packed {
        logic [63:0] data;                             // lane 0 in bits 7:0
        logic [7:0]  ctrl;                             // one bit per lane
    } xgmii_word_t;                                    // 72 bits

    typedef struct packed {
        logic        we;                               // beat strobe
        logic        start;                            // first beat of frame
        logic        last;                             // final beat of frame
        logic [3:0]  bcnt;                             // valid bytes 1..8
        logic [63:0] data;                             // frame byte 0 in lane 0
    } rx_beat_t;                                       // 71 bits

    typedef struct packed {
        logic        valid;                            // frame end pulse
        logic        overrun;                          // frame was dropped
        logic [15:0] len;                              // frame byte total
    } frame_done_t;                                    // 18 bits

    typedef struct packed {
        logic [31:0] frames;                           // kept frames
        logic [31:0] bytes;                            // bytes of kept frames
        logic [31:0] undersize;                        // kept, below min
        logic [31:0] oversize;                         // kept, above max_len
        logic [31:0] filter_drops;                     // rejected by da filter
        logic [31:0] overruns;                         // dropped on fifo space
    } rx_stats_t;                                      // 192 bits

    //************************************************************
    // fsm encodings
    //************************************************************
    typedef enum logic [1:0] {
        DEC_IDLE,                                      // waiting for start
        DEC_FRAME,                                     // in frame, word held
        DEC_TAIL                                       // partial last beat pending
    } dec_state_t;

    typedef enum logic {
        FILT_PASS,                                     // frame accepted
        FILT_DROP                                      // frame rejected
    } filt_state_t;

endpackage

// File: rx_sync_fifo.sv
module rx_sync_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 16
) (
    input  logic                       usr_clk,
    input  logic                       usr_rst_,
    input  logic                       wr_en,
    input  logic [WIDTH-1:0]           wr_data,
    input  logic                       rd_en,
    output logic [WIDTH-1:0]           rd_data,    // head entry, show-ahead
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] used        // entries held
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic             wr_ok;
    logic             rd_ok;

    assign empty   = (used == '0);
    assign full    = (used == ($clog2(DEPTH+1))'(DEPTH));
    assign wr_ok   = wr_en && !full;                   // write on full ignored
    assign rd_ok   = rd_en && !empty;                  // read on empty ignored
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge usr_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge usr_clk) begin
        if (!usr_rst_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            used <= used + wr_ok - rd_ok;              // net occupancy change
        end
    end

endmodule

// File: xgmii_rx_decoder.sv
module xgmii_rx_decoder import mac_rx_pkg::*; (
    input  logic        usr_clk,
    input  logic        usr_rst_,
    input  logic        rx_en,                         // frame gate, checked at start
    input  xgmii_word_t xgmii,
    output rx_beat_t    beat
);

    dec_state_t  state;
    logic [63:0] hold;                                 // one word of delay
    logic        hold_vld;                             // hold has frame data
    logic        sof_pend;                             // next beat gets start
    logic [3:0]  tail_bcnt;                            // bytes in tail beat
    logic        is_sof;
    logic        eof_hit;
    logic [2:0]  eof_lane;                             // lowest end lane
    logic [63:0] tail_data;
    logic        emit;
    logic        emit_last;

    //************************************************************
    // word decode
    //************************************************************
    assign is_sof = xgmii.ctrl[0] && (xgmii.data[7:0] == XGMII_START);

    always_comb begin
        eof_hit  = 1'b0;
        eof_lane = 3'd0;
        for (int i = BEAT_BYTES - 1; i >= 0; i--) begin  // downward so lowest lane wins
            if (xgmii.ctrl[i] && ((xgmii.data[8*i +: 8] == XGMII_TERM) ||
                                  (xgmii.data[8*i +: 8] == XGMII_IDLE))) begin
                eof_hit  = 1'b1;                       // stray idle also ends frame
                eof_lane = 3'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < BEAT_BYTES; i++) begin
            tail_data[8*i +: 8] = (i < eof_lane) ? xgmii.data[8*i +: 8] : 8'h00; // clear past end
        end
    end

    // held word goes out when the next word is seen
    assign emit      = (state == DEC_TAIL) || ((state == DEC_FRAME) && hold_vld);
    assign emit_last = (state == DEC_TAIL) ||
                       ((state == DEC_FRAME) && eof_hit && (eof_lane == 3'd0));

    //************************************************************
    // beat output and fsm
    //************************************************************
    always_ff @(posedge usr_clk) begin
        if (!usr_rst_) begin
            state      <= DEC_IDLE;
            hold_vld   <= 1'b0;
            sof_pend   <= 1'b0;
            beat.we    <= 1'b0;
            beat.start <= 1'b0;
            beat.last  <= 1'b0;
        end else begin
            beat.we    <= emit;
            beat.start <= emit && sof_pend;
            beat.last  <= emit && emit_last;
            beat.bcnt  <= (state == DEC_TAIL) ? tail_bcnt : 4'(BEAT_BYTES);
            beat.data  <= hold;                        // always the held word
            if (emit) begin
                sof_pend <= 1'b0;
            end
            case (state)
                DEC_IDLE: begin
                    if (is_sof && rx_en) begin         // preamble lanes discarded
                        state    <= DEC_FRAME;
                        hold_vld <= 1'b0;
                        sof_pend <= 1'b1;
                    end
                end
                DEC_FRAME: begin
                    if (!eof_hit) begin
                        hold     <= xgmii.data;        // plain data word
                        hold_vld <= 1'b1;
                    end else if (eof_lane == 3'd0) begin
                        state <= DEC_IDLE;             // held word was the last
                    end else begin
                        hold      <= tail_data;        // k bytes left for tail
                        tail_bcnt <= {1'b0, eof_lane};
                        state     <= DEC_TAIL;
                    end
                end
                DEC_TAIL: begin
                    state <= DEC_IDLE;                 // tail beat sent this edge
                end
                default: begin
                    state <= DEC_IDLE;
                end
            endcase
        end
    end

endmodule

// File: rx_addr_filter.sv
module rx_addr_filter import mac_rx_pkg::*; (
    input  logic        usr_clk,
    input  logic        usr_rst_,
    input  rx_beat_t    in_beat,
    input  logic [47:0] mac_addr,                      // byte 0 in bits 47:40
    input  logic        bcast_en,
    input  logic        prom_mode,
    output rx_beat_t    out_beat,
    output logic        drop                           // pulse on rejected start
);

    filt_state_t st;                                   // decision for rest of frame
    logic [47:0] dst;                                  // destination address
    logic        addr_ok;
    logic        keep;

    always_comb begin
        for (int i = 0; i < 6; i++) begin
            dst[47 - 8*i -: 8] = in_beat.data[8*i +: 8]; // lane order to address order
        end
    end

    assign addr_ok = prom_mode ||
                     (dst == mac_addr) ||
                     (bcast_en && (dst == 48'hffff_ffff_ffff));
    assign keep    = in_beat.start ? addr_ok : (st == FILT_PASS);

    always_ff @(posedge usr_clk) begin
        if (!usr_rst_) begin
            st             <= FILT_PASS;
            drop           <= 1'b0;
            out_beat.we    <= 1'b0;
            out_beat.start <= 1'b0;
            out_beat.last  <= 1'b0;
        end else begin
            out_beat.we    <= in_beat.we && keep;      // strip rejected beats
            out_beat.start <= in_beat.start;
            out_beat.last  <= in_beat.last;
            out_beat.bcnt  <= in_beat.bcnt;
            out_beat.data  <= in_beat.data;
            drop           <= in_beat.we && in_beat.start && !addr_ok;
            if (in_beat.we) begin
                if (in_beat.last) begin
                    st <= FILT_PASS;                   // back to default between frames
                end else if (in_beat.start) begin
                    st <= addr_ok ? FILT_PASS : FILT_DROP;
                end
            end
        end
    end

endmodule

// File: rx_frame_buffer.sv
module rx_frame_buffer import mac_rx_pkg::*; (
    input  logic        usr_clk,
    input  logic        usr_rst_,
    input  rx_beat_t    in_beat,                       // from address filter
    input  logic        rd_en,                         // pop data fifo
    input  logic        len_rd_en,                     // pop length fifo
    output rx_beat_t    rd_beat,
    output logic        rd_empty,
    output logic [15:0] len_dout,
    output logic        len_empty,
    output frame_done_t done                           // frame end report
);

    logic [$clog2(RX_FIFO_DEPTH+1)-1:0] data_used;
    logic        len_full;
    logic        dropping;                             // current frame dropped
    logic        drop_now;
    logic        data_wr;
    logic        len_wr;
    logic [15:0] len_acc;                              // bytes so far
    logic [15:0] len_tot;                              // bytes incl this beat

    //************************************************************
    // overrun decision and length count
    //************************************************************
    // decided once per frame, on its start beat
    assign drop_now = in_beat.start ?
                      ((data_used > RX_FIFO_DEPTH - MAX_FRAME_BEATS) || len_full) :
                      dropping;
    assign len_tot  = (in_beat.start ? 16'd0 : len_acc) + 16'(in_beat.bcnt);
    assign data_wr  = in_beat.we && !drop_now;
    assign len_wr   = data_wr && in_beat.last;         // total goes with last beat

    always_ff @(posedge usr_clk) begin
        if (!usr_rst_) begin
            dropping   <= 1'b0;
            len_acc    <= 16'd0;
            done.valid <= 1'b0;
        end else begin
            if (in_beat.we) begin
                dropping <= drop_now;                  // hold for rest of frame
                len_acc  <= len_tot;
            end
            done.valid   <= in_beat.we && in_beat.last;
            done.overrun <= drop_now;
            done.len     <= len_tot;
        end
    end

    //************************************************************
    // fifos
    //************************************************************
    rx_sync_fifo #(
        .WIDTH ($bits(rx_beat_t)),
        .DEPTH (RX_FIFO_DEPTH)
    ) u_data_fifo (
        .usr_clk  (usr_clk),
        .usr_rst_ (usr_rst_),
        .wr_en    (data_wr),
        .wr_data  (in_beat),
        .rd_en    (rd_en),
        .rd_data  (rd_beat),
        .empty    (rd_empty),
        .full     (),                                  // space kept by drop rule
        .used     (data_used)
    );

    rx_sync_fifo #(
        .WIDTH (16),
        .DEPTH (LEN_FIFO_DEPTH)
    ) u_len_fifo (
        .usr_clk  (usr_clk),
        .usr_rst_ (usr_rst_),
        .wr_en    (len_wr),
        .wr_data  (len_tot),
        .rd_en    (len_rd_en),
        .rd_data  (len_dout),
        .empty    (len_empty),
        .full     (len_full),
        .used     ()
    );

endmodule

// File: rx_stats.sv
module rx_stats import mac_rx_pkg::*; (
    input  logic        usr_clk,
    input  logic        usr_rst_,
    input  frame_done_t done,                          // frame end from buffer
    input  logic        filt_drop,                     // rejected frame pulse
    input  logic [15:0] max_len,                       // oversize limit
    input  logic        stat_clr,                      // zero all counters
    output rx_stats_t   stats
);

    logic kept;                                        // frame written to fifos
    logic lost;                                        // frame dropped on space

    assign kept = done.valid && !done.overrun;
    assign lost = done.valid && done.overrun;

    always_ff @(posedge usr_clk) begin
        if (!usr_rst_) begin
            stats <= '0;
        end else if (stat_clr) begin
            stats <= '0;                               // same-cycle events lost
        end else begin
            if (kept) begin
                stats.frames <= stats.frames + 32'd1;
                stats.bytes  <= stats.bytes + 32'(done.len);
                if (done.len < 16'(MIN_FRAME_BYTES)) begin
                    stats.undersize <= stats.undersize + 32'd1;
                end
                if (done.len > max_len) begin
                    stats.oversize <= stats.oversize + 32'd1;
                end
            end
            if (lost) begin
                stats.overruns <= stats.overruns + 32'd1;
            end
            if (filt_drop) begin
                stats.filter_drops <= stats.filter_drops + 32'd1;
            end
        end
    end

endmodule

// File: mac_rx_core.sv
module mac_rx_core import mac_rx_pkg::*; (
    input  logic        usr_clk,
    input  logic        usr_rst_,
    input  logic        rx_en,
    input  xgmii_word_t xgmii,
    input  logic [47:0] mac_addr,
    input  logic        bcast_en,
    input  logic        prom_mode,
    input  logic [15:0] max_len,
    input  logic        rd_en,
    input  logic        len_rd_en,
    input  logic        stat_clr,
    output rx_beat_t    rd_beat,
    output logic        rd_empty,
    output logic [15:0] len_dout,
    output logic        len_empty,
    output rx_stats_t   stats
);

    rx_beat_t    dec_beat;                             // decoder out, 2 cycles in
    rx_beat_t    filt_beat;                            // filtered, 1 more cycle
    logic        filt_drop;
    frame_done_t done;

    xgmii_rx_decoder u_dec (
        .usr_clk  (usr_clk),
        .usr_rst_ (usr_rst_),
        .rx_en    (rx_en),
        .xgmii    (xgmii),
        .beat     (dec_beat)
    );

    rx_addr_filter u_filt (
        .usr_clk   (usr_clk),
        .usr_rst_  (usr_rst_),
        .in_beat   (dec_beat),
        .mac_addr  (mac_addr),
        .bcast_en  (bcast_en),
        .prom_mode (prom_mode),
        .out_beat  (filt_beat),
        .drop      (filt_drop)
    );

    rx_frame_buffer u_buf (
        .usr_clk   (usr_clk),
        .usr_rst_  (usr_rst_),
        .in_beat   (filt_beat),
        .rd_en     (rd_en),
        .len_rd_en (len_rd_en),
        .rd_beat   (rd_beat),
        .rd_empty  (rd_empty),
        .len_dout  (len_dout),
        .len_empty (len_empty),
        .done      (done)
    );

    rx_stats u_stats (
        .usr_clk   (usr_clk),
        .usr_rst_  (usr_rst_),
        .done      (done),
        .filt_drop (filt_drop),
        .max_len   (max_len),
        .stat_clr  (stat_clr),
        .stats     (stats)
    );

endmodule

// File: mac_rx_core_props.sv
module mac_rx_core_props import mac_rx_pkg::*; (
    input logic                               usr_clk,
    input logic                               usr_rst_,
    input rx_beat_t                           filt_beat,
    input logic                               data_wr,     // data fifo write
    input logic [$clog2(RX_FIFO_DEPTH+1)-1:0] data_used,
    input frame_done_t                        done
);

    logic in_frame;                                    // start written, last not yet

    always_ff @(posedge usr_clk) begin
        if (!usr_rst_) begin
            in_frame <= 1'b0;
        end else if (data_wr) begin
            in_frame <= !filt_beat.last;
        end
    end

    //************************************************************
    // pipeline properties
    //************************************************************
    no_write_when_full: assert property (@(posedge usr_clk) disable iff (!usr_rst_)
        data_wr |-> (data_used < RX_FIFO_DEPTH)) else $error("data fifo written while full");

    bcnt_in_range: assert property (@(posedge usr_clk) disable iff (!usr_rst_)
        filt_beat.we |-> (filt_beat.bcnt >= 4'd1 && filt_beat.bcnt <= 4'd8))
        else $error("bcnt outside 1..8");

    last_after_start: assert property (@(posedge usr_clk) disable iff (!usr_rst_)
        (data_wr && filt_beat.last && !filt_beat.start) |-> in_frame)
        else $error("last beat written without a start beat");

    done_single: assert property (@(posedge usr_clk) disable iff (!usr_rst_)
        done.valid |=> !done.valid) else $error("done high two cycles in a row");

endmodule

bind mac_rx_core mac_rx_core_props u_props (
    .usr_clk   (usr_clk),
    .usr_rst_  (usr_rst_),
    .filt_beat (filt_beat),
    .data_wr   (u_buf.data_wr),
    .data_used (u_buf.data_used),
    .done      (done)
);

// File: tb_mac_rx_core.sv
module tb_mac_rx_core import mac_rx_pkg::*; ();

    localparam int FATE_GATED    = 0;                  // start seen with rx_en low
    localparam int FATE_FILTERED = 1;                  // rejected by da filter
    localparam int FATE_OVERRUN  = 2;                  // no room in buffer
    localparam int FATE_KEPT     = 3;

    logic        usr_clk = 1'b0;
    logic        usr_rst_;
    logic        rx_en;
    xgmii_word_t xgmii;
    logic [47:0] mac_addr;
    logic        bcast_en;
    logic        prom_mode;
    logic [15:0] max_len;
    logic        rd_en;
    logic        len_rd_en;
    logic        stat_clr;
    rx_beat_t    rd_beat;
    logic        rd_empty;
    logic [15:0] len_dout;
    logic        len_empty;
    rx_stats_t   stats;

    logic [31:0] lfsr = 32'h83c7_4e63;                 // galois lfsr state
    rx_beat_t    exp_beats [$];                        // expected data fifo contents
    logic [15:0] exp_lens [$];
    rx_stats_t   exp_stats;
    int          occ;                                  // model data fifo beats
    int          len_occ;                              // model length fifo entries
    logic        stall;                                // reader held off

    always #50 usr_clk = ~usr_clk;

    mac_rx_core UUT (.*);

    //************************************************************
    // reference model
    //************************************************************
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};                 // one step per bit
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic int frame_fate(input logic [47:0] dst);
        if (!rx_en) return FATE_GATED;
        if (!(prom_mode || (dst == mac_addr) || (bcast_en && (dst == '1)))) return FATE_FILTERED;
        if ((occ > RX_FIFO_DEPTH - MAX_FRAME_BEATS) || (len_occ == LEN_FIFO_DEPTH)) begin
            return FATE_OVERRUN;                       // whole frame lost
        end
        return FATE_KEPT;
    endfunction

    task automatic print_mismatch(input string name, input logic [191:0] exp_v,
                                  input logic [191:0] got_v);
        $display("FAILED at %0t signal %s expected %0h got %0h", $time, name, exp_v, got_v);
        $display("TEST FAILED");
    endtask

    task automatic print_error(input string msg);
        $display("%s (time %0t)", msg, $time);
        $display("TEST FAILED");
    endtask

    //************************************************************
    // stimulus
    //************************************************************
    task automatic send_word(input logic [63:0] data, input logic [7:0] ctrl);
        @(posedge usr_clk);
        #5;
        xgmii.data = data;
        xgmii.ctrl = ctrl;
    endtask

    task automatic send_idle(input int n);
        repeat (n) send_word({8{XGMII_IDLE}}, 8'hff);
    endtask

    task automatic send_frame(input logic [47:0] dst, input int len);
        logic [7:0]  b [200];
        rx_beat_t    e;
        logic [63:0] w;
        logic [7:0]  c;
        int          nb;
        int          k;
        int          idx;
        nb = (len + 7) / 8;
        for (int i = 0; i < len; i++) begin
            b[i] = (i < 6) ? dst[47 - 8*i -: 8] : 8'(rand_bits(8)); // da then payload
        end
        case (frame_fate(dst))
            FATE_FILTERED: exp_stats.filter_drops = exp_stats.filter_drops + 1;
            FATE_OVERRUN:  exp_stats.overruns = exp_stats.overruns + 1;
            FATE_KEPT: begin
                for (int bi = 0; bi < nb; bi++) begin
                    k       = (len - 8*bi > 8) ? 8 : len - 8*bi;
                    e.we    = 1'b1;
                    e.start = (bi == 0);
                    e.last  = (bi == nb - 1);
                    e.bcnt  = 4'(k);
                    for (int l = 0; l < 8; l++) begin
                        e.data[8*l +: 8] = (l < k) ? b[8*bi + l] : 8'h00; // unused lanes zero
                    end
                    exp_beats.push_back(e);
                end
                exp_lens.push_back(16'(len));
                occ     = occ + nb;
                len_occ = len_occ + 1;
                exp_stats.frames = exp_stats.frames + 1;
                exp_stats.bytes  = exp_stats.bytes + 32'(len);
                if (len < MIN_FRAME_BYTES) exp_stats.undersize = exp_stats.undersize + 1;
                if (len > max_len) exp_stats.oversize = exp_stats.oversize + 1;
            end
            default: ;                                 // gated frame leaves nothing
        endcase
        send_word({{7{8'h55}}, XGMII_START}, 8'h01);   // preamble in lanes 1..7
        for (int wi = 0; wi <= len / 8; wi++) begin
            w = '0;
            c = '0;
            for (int l = 0; l < 8; l++) begin
                idx = 8*wi + l;
                if (idx < len) begin
                    w[8*l +: 8] = b[idx];
                end else begin
                    w[8*l +: 8] = (idx == len) ? XGMII_TERM : XGMII_IDLE;
                    c[l]        = 1'b1;
                end
            end
            send_word(w, c);
        end
        send_idle(1 + int'(rand_bits(2) % 3));         // 1..3 idle words
    endtask

    //************************************************************
    // checker that pops both fifos
    //************************************************************
    always @(posedge usr_clk) begin
        #5;
        rd_en     = 1'b0;
        len_rd_en = 1'b0;
        if (usr_rst_ && !stall && !rd_empty) begin
            if (exp_beats.size() == 0) begin
                print_error("data FIFO holds a beat that no frame should have produced");
                $fatal(1, "unexpected beat");
            end
            assert (rd_beat == exp_beats[0]) else begin
                print_mismatch("rd_beat", 192'(exp_beats[0]), 192'(rd_beat));
                $fatal(1, "beat mismatch");
            end
            void'(exp_beats.pop_front());
            rd_en = 1'b1;                              // pops on next edge
            occ   = occ - 1;
        end
        if (usr_rst_ && !stall && !len_empty) begin
            if (exp_lens.size() == 0) begin
                print_error("length FIFO holds an entry that no frame should have produced");
                $fatal(1, "unexpected length");
            end
            assert (len_dout == exp_lens[0]) else begin
                print_mismatch("len_dout", 192'(exp_lens[0]), 192'(len_dout));
                $fatal(1, "length mismatch");
            end
            void'(exp_lens.pop_front());
            len_rd_en = 1'b1;
            len_occ   = len_occ - 1;
        end
    end

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_beats.size() != 0 || exp_lens.size() != 0 || !rd_empty || !len_empty)
               && n < 3000) begin
            @(posedge usr_clk);
            n++;
        end
        if (n == 3000) begin
            print_error("timed out waiting for the expected frames to reach the FIFOs");
            $fatal(1, "drain timeout");
        end
    endtask

    task automatic check_stats();
        int n;
        n = 0;
        while (stats != exp_stats && n < 50) begin     // counters settle a cycle late
            @(posedge usr_clk);
            n++;
        end
        assert (stats == exp_stats) else begin
            print_mismatch("stats", exp_stats, stats);
            $fatal(1, "stats mismatch");
        end
    endtask

    initial begin
        #(100 * 200000);
        print_error("simulation ran past its time limit");
        $fatal(1, "watchdog");
    end

    initial begin
        usr_rst_  = 1'b0;
        rx_en     = 1'b1;
        xgmii     = {{8{XGMII_IDLE}}, 8'hff};
        mac_addr  = 48'h02_11_22_33_44_55;
        bcast_en  = 1'b0;
        prom_mode = 1'b0;
        max_len   = 16'd150;
        rd_en     = 1'b0;
        len_rd_en = 1'b0;
        stat_clr  = 1'b0;
        stall     = 1'b0;
        occ       = 0;
        len_occ   = 0;
        exp_stats = '0;
        repeat (10) @(posedge usr_clk);
        #5 usr_rst_ = 1'b1;
        send_idle(4);

        // unicast frames at both size limits and random lengths
        send_frame(mac_addr, 8);
        send_frame(mac_addr, 63);
        send_frame(mac_addr, 64);
        send_frame(mac_addr, 150);
        send_frame(mac_addr, 151);
        send_frame(mac_addr, 190);
        repeat (8) send_frame(mac_addr, 8 + int'(rand_bits(8) % 183));
        wait_drain();
        check_stats();

        // address filter
        send_frame(48'h02_aa_bb_cc_dd_ee, 70);
        send_frame('1, 80);                            // bcast off
        send_idle(6);
        bcast_en = 1'b1;
        send_frame('1, 90);
        send_idle(6);
        prom_mode = 1'b1;
        send_frame(48'h02_aa_bb_cc_dd_ee, 100);
        send_frame(48'h00_00_00_00_00_01, 60);
        send_idle(6);
        prom_mode = 1'b0;
        bcast_en  = 1'b0;
        wait_drain();
        check_stats();

        // gating by rx_en
        @(posedge usr_clk);
        #5 rx_en = 1'b0;
        send_frame(mac_addr, 72);
        send_frame(mac_addr, 40);
        rx_en = 1'b1;
        send_frame(mac_addr, 88);
        wait_drain();
        check_stats();

        // reader stalled until the overrun rule fires
        stall = 1'b1;
        repeat (12) send_frame(mac_addr, 8 + int'(rand_bits(8) % 183));
        send_idle(6);
        if (exp_stats.overruns == 0) begin
            print_error("stalled reader did not lead to any overrun drop");
            $fatal(1, "no overrun");
        end
        check_stats();
        stall = 1'b0;
        wait_drain();
        repeat (3) send_frame(mac_addr, 8 + int'(rand_bits(8) % 183));
        wait_drain();
        check_stats();

        // counter clear
        @(posedge usr_clk);
        #5 stat_clr = 1'b1;
        @(posedge usr_clk);
        #5 stat_clr = 1'b0;
        exp_stats = '0;
        check_stats();

        $display("TEST OK");
        $finish;
    end

endmodule

// File: flist.f
mac_rx_pkg.sv
rx_sync_fifo.sv
xgmii_rx_decoder.sv
rx_addr_filter.sv
rx_frame_buffer.sv
rx_stats.sv
mac_rx_core.sv
mac_rx_core_props.sv
tb_mac_rx_core.sv

// File: run.sh
#!/bin/bash
# build and run the receive core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mac_rx_core -f flist.f -o sim_mac_rx
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/sim_mac_rx
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit $status
fi

exit 0
